// ==== compile.f ====
+incdir+test
hw/capture_pkg.sv
hw/sample_deserializer.sv
hw/capture_ram.sv
hw/dump_sequencer.sv
hw/uart_tx.sv
hw/hex_dump.sv
test/tb_hex_dump.sv

// ==== hw/capture_pkg.sv ====
package capture_pkg;

    // one I or Q sample as it arrives on the line
    typedef logic signed [7:0] sample_t;

    // one capture memory word
    // I sits in the low byte and Q in the high byte
    typedef struct packed {
        sample_t q;
        sample_t i;
    } capture_word_t;

    // byte handed to the UART transmitter
    typedef logic [7:0] uart_byte_t;

    // data bits per input frame, I byte then Q byte, MSB first
    localparam int FRAME_BITS = 16;

    // number of memory banks, selected by the top address bits
    localparam int BANKS = 4;

endpackage

// ==== hw/capture_ram.sv ====
module capture_ram #(
    parameter int ADDR_W = 14
) (
    input  logic                       clk,
    input  logic [ADDR_W-1:0]          addr,
    input  capture_pkg::capture_word_t wdata,
    input  logic                       we,
    output capture_pkg::capture_word_t rdata
);

    localparam int SEL_W = $clog2(capture_pkg::BANKS);
    localparam int ROW_W = ADDR_W - SEL_W;
    localparam int ROWS  = 2 ** ROW_W;

    logic [SEL_W-1:0]           sel;
    logic [SEL_W-1:0]           sel_q;
    logic [ROW_W-1:0]           row;
    capture_pkg::capture_word_t bank_rdata [capture_pkg::BANKS];

    assign sel = addr[ADDR_W-1 -: SEL_W];  // bank from top bits
    assign row = addr[ROW_W-1:0];

    for (genvar b = 0; b < capture_pkg::BANKS; b++) begin : g_bank
        capture_pkg::capture_word_t mem [ROWS];
        capture_pkg::capture_word_t rd_q;
        logic                       cs;

        assign cs = (sel == SEL_W'(b));

        // a read during a write returns the old word
        always_ff @(posedge clk) begin
            if (cs) begin
                if (we) begin
                    mem[row] <= wdata;
                end
                rd_q <= mem[row];
            end
        end

        assign bank_rdata[b] = rd_q;
    end

    // output mux follows the bank that was read
    always_ff @(posedge clk) begin
        sel_q <= sel;
    end

    assign rdata = bank_rdata[sel_q];

endmodule

// ==== hw/dump_sequencer.sv ====
module dump_sequencer #(
    parameter int ADDR_W = 14
) (
    input  logic                       clk,
    input  logic                       reset,
    input  capture_pkg::capture_word_t word,
    input  logic                       word_stb,
    output logic [ADDR_W-1:0]          ram_addr,
    output capture_pkg::capture_word_t ram_wdata,
    output logic                       ram_we,
    input  capture_pkg::capture_word_t ram_rdata,
    output capture_pkg::uart_byte_t    tx_data,
    output logic                       tx_start,
    input  logic                       tx_busy,
    output logic                       full,
    output logic                       done
);

    typedef enum logic [2:0] {
        ST_CAPTURE,
        ST_READ_WAIT,
        ST_SEND_LO,
        ST_SEND_HI,
        ST_DRAIN,
        ST_FINISHED
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr;
    logic              last_addr;
    logic              tx_ready;
    logic              sending;

    assign last_addr = (addr == {ADDR_W{1'b1}});
    assign tx_ready  = !tx_busy;
    assign sending   = (state == ST_SEND_LO) || (state == ST_SEND_HI);

    assign ram_addr  = addr;
    assign ram_wdata = word;
    assign ram_we    = (state == ST_CAPTURE) && word_stb;  // strobes outside capture dropped

    // rdata stays valid while the address is held
    assign tx_start = sending && tx_ready;
    assign tx_data  = (state == ST_SEND_HI) ? capture_pkg::uart_byte_t'(ram_rdata.q)
                                            : capture_pkg::uart_byte_t'(ram_rdata.i);

    assign full = (state != ST_CAPTURE);
    assign done = (state == ST_FINISHED);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            addr  <= '0;
        end else begin
            case (state)
                ST_CAPTURE: begin
                    if (ram_we) begin
                        addr <= addr + 1'b1;  // wraps to 0 after the last word
                        if (last_addr) begin
                            state <= ST_READ_WAIT;
                        end
                    end
                end
                ST_READ_WAIT: begin
                    state <= ST_SEND_LO;  // one cycle read latency
                end
                ST_SEND_LO: begin
                    if (tx_start) begin
                        state <= ST_SEND_HI;
                    end
                end
                ST_SEND_HI: begin
                    if (tx_start) begin
                        addr  <= addr + 1'b1;
                        state <= last_addr ? ST_DRAIN : ST_READ_WAIT;
                    end
                end
                ST_DRAIN: begin
                    if (tx_ready) begin  // last stop bit out
                        state <= ST_FINISHED;
                    end
                end
                default: begin
                    state <= ST_FINISHED;  // idle until reset
                end
            endcase
        end
    end

endmodule

// ==== hw/hex_dump.sv ====
module hex_dump #(
    parameter int ADDR_W       = 14,
    parameter int CLKS_PER_BIT = 40000  // 48 MHz at 1200 baud
) (
    input  logic clk,
    input  logic reset,
    input  logic sig,
    output logic tx,
    output logic full,
    output logic done
);

    capture_pkg::capture_word_t word;
    logic                       word_stb;
    logic [ADDR_W-1:0]          ram_addr;
    capture_pkg::capture_word_t ram_wdata;
    logic                       ram_we;
    capture_pkg::capture_word_t ram_rdata;
    capture_pkg::uart_byte_t    tx_data;
    logic                       tx_start;
    logic                       tx_busy;

    sample_deserializer deser0 (
        .clk      (clk),
        .reset    (reset),
        .sig      (sig),
        .word     (word),
        .word_stb (word_stb)
    );

    capture_ram #(
        .ADDR_W (ADDR_W)
    ) ram0 (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    dump_sequencer #(
        .ADDR_W (ADDR_W)
    ) seq0 (
        .clk       (clk),
        .reset     (reset),
        .word      (word),
        .word_stb  (word_stb),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .full      (full),
        .done      (done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) tx0 (
        .clk   (clk),
        .reset (reset),
        .data  (tx_data),
        .start (tx_start),
        .tx    (tx),
        .busy  (tx_busy)
    );

endmodule

// ==== hw/sample_deserializer.sv ====
module sample_deserializer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sig,
    output capture_pkg::capture_word_t word,
    output logic                       word_stb
);

    localparam int CNT_W = $clog2(capture_pkg::FRAME_BITS);
    localparam int HALF  = capture_pkg::FRAME_BITS / 2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_EMIT
    } state_t;

    state_t                            state;
    logic [CNT_W-1:0]                  bit_cnt;
    logic [capture_pkg::FRAME_BITS-1:0] shift_q;
    logic                              last_bit;

    assign last_bit = (bit_cnt == CNT_W'(capture_pkg::FRAME_BITS - 1));

    // first byte on the line is I, second is Q
    assign word = '{
        q: capture_pkg::sample_t'(shift_q[HALF-1:0]),
        i: capture_pkg::sample_t'(shift_q[capture_pkg::FRAME_BITS-1:HALF])
    };
    assign word_stb = (state == ST_EMIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    bit_cnt <= '0;
                    if (!sig) begin  // start bit
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        state <= ST_EMIT;
                    end
                end
                // line is not looked at during the strobe cycle
                default: state <= ST_IDLE;
            endcase
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (state == ST_SHIFT) begin
            shift_q <= {shift_q[capture_pkg::FRAME_BITS-2:0], sig};
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx #(
    parameter int CLKS_PER_BIT = 40000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  capture_pkg::uart_byte_t data,
    input  logic                    start,
    output logic                    tx,
    output logic                    busy
);

    localparam int CNT_W   = $clog2(CLKS_PER_BIT + 1);
    localparam int FRAME_W = 10;  // start, 8 data, stop
    localparam int BIT_W   = $clog2(FRAME_W);

    logic [CNT_W-1:0]   baud_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    logic [FRAME_W-1:0] shift_q;
    logic               bit_end;
    logic               last_bit;

    assign bit_end  = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_cnt == BIT_W'(FRAME_W - 1));
    assign tx       = shift_q[0];  // LSB first

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            shift_q  <= '1;  // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (start) begin
                shift_q  <= {1'b1, data, 1'b0};
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            shift_q  <= {1'b1, shift_q[FRAME_W-1:1]};
            if (last_bit) begin
                busy <= 1'b0;  // stop bit complete
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_hex_dump -f compile.f \
    && ./obj_dir/Vtb_hex_dump > sim.log 2>&1 \
    || echo "build or simulation failed"

grep -q "Finished with no errors" sim.log 2>/dev/null && echo "PASS" && exit 0
echo "FAIL"
exit 1

// ==== test/tb_hex_dump_tasks.svh ====
`ifndef TB_HEX_DUMP_TASKS_SVH
`define TB_HEX_DUMP_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t",
                 name, actual, expected, $time);
    end
endtask

task automatic report_failure(input string what);
    error_count++;
    $display("ERROR: %s at %0t", what, $time);
endtask

task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    sig   <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
endtask

function automatic capture_pkg::capture_word_t random_word();
    capture_pkg::capture_word_t w;
    logic [31:0]                r;
    r   = $urandom();
    w.i = r[7:0];
    w.q = r[15:8];
    return w;
endfunction

// start bit, I then Q MSB first, then idle high
task automatic send_frame(input capture_pkg::capture_word_t w);
    logic [capture_pkg::FRAME_BITS-1:0] bits;
    bits = {w.i, w.q};
    @(posedge clk);
    sig <= 1'b0;
    for (int n = capture_pkg::FRAME_BITS - 1; n >= 0; n--) begin
        @(posedge clk);
        sig <= bits[n];
    end
    @(posedge clk);
    sig <= 1'b1;
    repeat (2) @(posedge clk);
endtask

// polls tx at falling clock edges and samples each bit mid-bit
task automatic receive_byte(output capture_pkg::uart_byte_t b);
    int         n;
    logic [7:0] data;
    n    = 0;
    data = '0;
    @(negedge clk);
    while (tx && n < BYTE_TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (tx) begin
        report_failure("no start bit seen on tx");
        b = '0;
    end else begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        check_value("tx start bit", 32'(tx), 32'h0);
        for (int k = 0; k < 8; k++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[k] = tx;  // LSB first
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value("tx stop bit", 32'(tx), 32'h1);
        b = data;
    end
endtask

task automatic receive_bytes(input int count);
    capture_pkg::uart_byte_t b;
    for (int n = 0; n < count; n++) begin
        receive_byte(b);
        rx_q.push_back(b);
    end
endtask

task automatic wait_for_full();
    int n;
    n = 0;
    @(negedge clk);
    while (!full && n < FULL_TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!full) begin
        report_failure("full did not rise after the last frame");
    end
endtask

task automatic test_reset_state();
    logic stayed_high;
    stayed_high = 1'b1;
    @(negedge clk);
    check_value("tx", 32'(tx), 32'h1);
    check_value("full", 32'(full), 32'h0);
    check_value("done", 32'(done), 32'h0);
    repeat (IDLE_CYCLES) begin
        @(negedge clk);
        if (tx !== 1'b1) begin
            stayed_high = 1'b0;
        end
    end
    check_value("tx idle without frames", 32'(stayed_high), 32'h1);
endtask

task automatic test_fill();
    capture_pkg::capture_word_t w;
    expect_q.delete();
    rx_q.delete();
    for (int f = 0; f < DEPTH; f++) begin
        w = random_word();
        expect_q.push_back(w.i);
        expect_q.push_back(w.q);
        send_frame(w);
        if (f < DEPTH - 1) begin
            @(negedge clk);
            check_value($sformatf("full after frame %0d", f), 32'(full), 32'h0);
        end else begin
            wait_for_full();
        end
    end
endtask

// late frames go in while the dump is running and must not show up
task automatic test_dump(input int late_frames);
    fork
        receive_bytes(2 * DEPTH);
        begin
            repeat (3 * CLKS_PER_BIT) @(posedge clk);
            for (int f = 0; f < late_frames; f++) begin
                send_frame(random_word());
            end
        end
    join
    for (int n = 0; n < 2 * DEPTH; n++) begin
        check_value($sformatf("dump byte %0d", n), 32'(rx_q[n]), 32'(expect_q[n]));
    end
    check_value("full during dump", 32'(full), 32'h1);
endtask

task automatic test_completion();
    int   n;
    logic quiet;
    n     = 0;
    quiet = 1'b1;
    @(negedge clk);
    while (!done && n < DONE_TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (!done) begin
        report_failure("done did not rise after the last byte");
    end
    repeat (QUIET_CYCLES) begin
        @(negedge clk);
        if (tx !== 1'b1 || done !== 1'b1) begin
            quiet = 1'b0;
        end
    end
    check_value("tx idle after done", 32'(quiet), 32'h1);
endtask

`endif

// ==== test/tb_hex_dump.sv ====
module tb_hex_dump;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_W        = 4;
    localparam int CLKS_PER_BIT  = 8;
    localparam int DEPTH         = 2 ** ADDR_W;
    localparam int LATE_FRAMES   = 3;
    localparam int SEED          = 32'h9c26;
    localparam int FULL_TIMEOUT  = 100;                    // cycles
    localparam int BYTE_TIMEOUT  = 4 * 10 * CLKS_PER_BIT;  // cycles to the next start bit
    localparam int DONE_TIMEOUT  = 2 * 10 * CLKS_PER_BIT;
    localparam int IDLE_CYCLES   = 50;
    localparam int QUIET_CYCLES  = 200;

    logic clk;
    logic reset;
    logic sig;
    logic tx;
    logic full;
    logic done;

    int error_count;
    int check_count;

    capture_pkg::uart_byte_t expect_q[$];  // bytes in the order they must leave
    capture_pkg::uart_byte_t rx_q[$];      // bytes decoded from tx

    hex_dump #(
        .ADDR_W       (ADDR_W),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut0 (
        .clk   (clk),
        .reset (reset),
        .sig   (sig),
        .tx    (tx),
        .full  (full),
        .done  (done)
    );

`include "tb_hex_dump_tasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        reset       = 1'b1;
        sig         = 1'b1;  // line idles high
        error_count = 0;
        check_count = 0;
        void'($urandom(SEED));

        // first capture and dump with late frames arriving during the dump
        apply_reset();
        test_reset_state();
        test_fill();
        test_dump(LATE_FRAMES);
        test_completion();

        // second run with new data
        apply_reset();
        test_reset_state();
        test_fill();
        test_dump(0);
        test_completion();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
